// ==== logic/fifo_defs.svh ====
`ifndef FIFO_DEFS_SVH
`define FIFO_DEFS_SVH

//////////////////////////////////////////////////
// Packet buffer sizing

// Width of one data word in bits
`define FIFO_WIDTH     32

// Buffer depth in words, small enough to fill quickly
`define FIFO_DEPTH     16

// RAM address bits, log2 of the depth
// Pointers carry one more bit for the wrap
`define FIFO_ADDR_BITS 4

`endif

// ==== logic/fifo_pkg.sv ====
`include "fifo_defs.svh"

package fifo_pkg;

	//////////////////////////////////////////////////
	// Scalar types

	typedef logic [`FIFO_WIDTH-1:0]     fifo_word_t;   // One data word
	typedef logic [`FIFO_ADDR_BITS-1:0] fifo_addr_t;   // RAM address or read offset
	typedef logic [`FIFO_ADDR_BITS:0]   fifo_ptr_t;    // Address plus wrap bit

	// Fill or free count, 0 to DEPTH inclusive
	typedef logic [`FIFO_ADDR_BITS:0]   fifo_count_t;

	//////////////////////////////////////////////////
	// Request bundles

	// Write side, all in wr_clk
	typedef struct packed {
		logic       en;         // Push data this cycle
		logic       commit;     // Make everything pushed so far readable
		logic       rollback;   // Drop everything since the last commit
		fifo_word_t data;       // Word to push
	} fifo_wr_req_t;

	// Read side, all in rd_clk
	// pop_single and pop_packet are exclusive
	typedef struct packed {
		logic        en;           // Read one word
		fifo_addr_t  offset;       // Offset from the packet start
		logic        pop_single;   // Free one word
		logic        pop_packet;   // Free packet_size words
		fifo_count_t packet_size;  // Length of the packet to free
	} fifo_rd_req_t;

endpackage

// ==== logic/dual_clock_ram.sv ====
`timescale 1ns/1ps
`include "fifo_defs.svh"

module dual_clock_ram
	import fifo_pkg::*;
#(
	parameter int  DEPTH     = `FIFO_DEPTH,
	parameter type payload_t = logic [`FIFO_WIDTH-1:0]
) (
	// Write port
	input  logic       wr_clk,
	input  logic       wr_en,
	input  fifo_addr_t wr_addr,
	input  payload_t   wr_data,

	// Read port, two cycle latency
	input  logic       rd_clk,
	input  logic       rd_en,
	input  fifo_addr_t rd_addr,
	output payload_t   rd_data
);

	//////////////////////////////////////////////////
	// Storage

	// Zero init so reads of unwritten words are defined
	payload_t mem [DEPTH] = '{default: '0};

	payload_t ram_q   = '0;    // Block RAM read register
	payload_t out_q   = '0;    // Output register
	logic     rd_en_q = 1'b0;  // Read strobe lined up with ram_q

	//////////////////////////////////////////////////
	// Write port

	always_ff @(posedge wr_clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	//////////////////////////////////////////////////
	// Read port

	always_ff @(posedge rd_clk) begin
		rd_en_q <= rd_en;             // Follows the word down the pipe
		if (rd_en)
			ram_q <= mem[rd_addr];    // First stage, inside the RAM
		if (rd_en_q)
			out_q <= ram_q;           // Second stage, holds until the next read
	end

	assign rd_data = out_q;

endmodule

// ==== logic/handshake_sync.sv ====
`timescale 1ns/1ps

module handshake_sync (
	// Side a, sender
	input  logic clk_a,
	input  logic reset_a,
	input  logic req_a,     // Single cycle request
	output logic ack_a,     // Single cycle, side b has taken the request
	output logic busy_a,    // Request in flight, hold the payload

	// Side b, receiver
	input  logic clk_b,
	input  logic reset_b,
	output logic req_b      // Single cycle, payload may be sampled
);

	logic       toggle_a;   // Flips once per accepted request
	logic [1:0] ack_sync;   // Return chain, [0] is the metastable stage
	logic       ack_last;   // Previous return value for edge detect
	logic       pending;    // Toggle sent but not yet back

	logic [1:0] req_sync;   // Forward chain, [0] is the metastable stage
	logic       req_last;   // Previous forward value, also sent back

	//////////////////////////////////////////////////
	// Side a

	assign pending = toggle_a ^ ack_sync[1];
	assign busy_a  = req_a | pending;        // High from the request pulse on
	assign ack_a   = ack_sync[1] ^ ack_last;

	always_ff @(posedge clk_a) begin
		if (reset_a) begin
			toggle_a <= 1'b0;
			ack_sync <= 2'b00;
			ack_last <= 1'b0;
		end else begin
			// Requests while one is pending are dropped
			if (req_a && !pending)
				toggle_a <= ~toggle_a;
			ack_sync <= {ack_sync[0], req_last};  // Bring the toggle home
			ack_last <= ack_sync[1];
		end
	end

	//////////////////////////////////////////////////
	// Side b

	// Edge on the synced toggle means a new request
	assign req_b = req_sync[1] ^ req_last;

	always_ff @(posedge clk_b) begin
		if (reset_b) begin
			req_sync <= 2'b00;
			req_last <= 1'b0;
		end else begin
			req_sync <= {req_sync[0], toggle_a};
			// Updates on the edge that consumes req_b
			// so the acknowledge never beats the load
			req_last <= req_sync[1];
		end
	end

endmodule

// ==== logic/packet_fifo.sv ====
`timescale 1ns/1ps
`include "fifo_defs.svh"

module packet_fifo
	import fifo_pkg::*;
#(
	parameter int DEPTH = `FIFO_DEPTH
) (
	// Write side, wr_clk domain
	input  logic         wr_clk,
	input  logic         wr_reset,
	input  fifo_wr_req_t wr_req,
	output fifo_count_t  wr_size,    // Free words, lags the reader

	// Read side, rd_clk domain
	input  logic         rd_clk,
	input  logic         rd_reset,
	input  fifo_rd_req_t rd_req,
	output fifo_word_t   rd_data,    // Two cycles after rd_req.en
	output fifo_count_t  rd_size     // Committed words, lags the writer
);

	//////////////////////////////////////////////////
	// Pointers

	// wr_clk domain
	fifo_ptr_t wr_ptr;          // Next word to push
	fifo_ptr_t committed_ptr;   // End of the committed data
	fifo_ptr_t tail_capture;    // Committed pointer on its way to rd_clk
	fifo_ptr_t head_ptr;        // Read pointer as last seen from wr_clk

	// rd_clk domain
	fifo_ptr_t rd_ptr;          // Start of the oldest packet
	fifo_ptr_t tail_ptr;        // Committed pointer as last seen from rd_clk
	fifo_ptr_t head_capture;    // Read pointer on its way to wr_clk

	fifo_addr_t wr_addr;
	fifo_addr_t rd_addr;

	// Crossing control
	logic tail_send;            // Request pulse, wr_clk
	logic tail_busy;
	logic tail_arrive;          // Crossed pulse, rd_clk
	logic head_send;            // Request pulse, rd_clk
	logic head_busy;
	logic head_arrive;          // Crossed pulse, wr_clk

	assign wr_addr = wr_ptr[`FIFO_ADDR_BITS-1:0];
	assign rd_addr = rd_ptr[`FIFO_ADDR_BITS-1:0] + rd_req.offset;  // Wraps mod DEPTH

	//////////////////////////////////////////////////
	// Packet storage

	dual_clock_ram #(
		.DEPTH     (DEPTH),
		.payload_t (fifo_word_t)
	) i_ram (
		.wr_clk  (wr_clk),
		.wr_en   (wr_req.en),
		.wr_addr (wr_addr),
		.wr_data (wr_req.data),
		.rd_clk  (rd_clk),
		.rd_en   (rd_req.en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	//////////////////////////////////////////////////
	// Write pointer, commit and rollback

	always_ff @(posedge wr_clk) begin
		if (wr_reset) begin
			wr_ptr        <= '0;
			committed_ptr <= '0;
		end else begin
			if (wr_req.en)
				wr_ptr <= wr_ptr + 1'b1;
			// Commit takes the pointer before this cycle's push
			if (wr_req.commit)
				committed_ptr <= wr_ptr;
			// Rollback overrides a same cycle push
			if (wr_req.rollback)
				wr_ptr <= committed_ptr;
		end
	end

	// Uncommitted words count as used
	assign wr_size = fifo_count_t'(DEPTH) + head_ptr - wr_ptr;

	//////////////////////////////////////////////////
	// Read pointer and pops

	always_ff @(posedge rd_clk) begin
		if (rd_reset) begin
			rd_ptr <= '0;
		end else if (rd_req.pop_single) begin
			if (rd_size != '0)
				rd_ptr <= rd_ptr + 1'b1;   // Ignore pops on an empty buffer
		end else if (rd_req.pop_packet) begin
			rd_ptr <= rd_ptr + rd_req.packet_size;
		end
	end

	assign rd_size = tail_ptr - rd_ptr;    // Wrap bit keeps 0 and DEPTH apart

	//////////////////////////////////////////////////
	// Tail crossing, wr_clk to rd_clk

	handshake_sync i_tail_sync (
		.clk_a   (wr_clk),
		.reset_a (wr_reset),
		.req_a   (tail_send),
		.ack_a   (),
		.busy_a  (tail_busy),
		.clk_b   (rd_clk),
		.reset_b (rd_reset),
		.req_b   (tail_arrive)
	);

	// Free running, send a fresh copy whenever idle
	always_ff @(posedge wr_clk) begin
		if (wr_reset)
			tail_send <= 1'b0;
		else
			tail_send <= ~tail_busy;
	end

	// Frozen while busy, so rd_clk may sample it on arrival
	always_ff @(posedge wr_clk) begin
		if (!tail_busy)
			tail_capture <= committed_ptr;
	end

	always_ff @(posedge rd_clk) begin
		if (rd_reset)
			tail_ptr <= '0;
		else if (tail_arrive)
			tail_ptr <= tail_capture;
	end

	//////////////////////////////////////////////////
	// Head crossing, rd_clk to wr_clk

	handshake_sync i_head_sync (
		.clk_a   (rd_clk),
		.reset_a (rd_reset),
		.req_a   (head_send),
		.ack_a   (),
		.busy_a  (head_busy),
		.clk_b   (wr_clk),
		.reset_b (wr_reset),
		.req_b   (head_arrive)
	);

	always_ff @(posedge rd_clk) begin
		if (rd_reset)
			head_send <= 1'b0;
		else
			head_send <= ~head_busy;
	end

	always_ff @(posedge rd_clk) begin
		if (!head_busy)
			head_capture <= rd_ptr;   // Space freed by pops so far
	end

	always_ff @(posedge wr_clk) begin
		if (wr_reset)
			head_ptr <= '0;
		else if (head_arrive)
			head_ptr <= head_capture;
	end

endmodule

// ==== logic/packet_fifo_top.sv ====
`timescale 1ns/1ps
`include "fifo_defs.svh"

module packet_fifo_top
	import fifo_pkg::*;
(
	//////////////////////////////////////////////////
	// Producer, wr_clk domain

	input  logic         wr_clk,
	input  logic         wr_reset,    // Synchronous, active high
	input  fifo_wr_req_t wr_req,      // en, commit, rollback, data
	output fifo_count_t  wr_size,     // Free words

	//////////////////////////////////////////////////
	// Consumer, rd_clk domain

	input  logic         rd_clk,
	input  logic         rd_reset,    // Synchronous, active high
	input  fifo_rd_req_t rd_req,      // en, offset, pops, packet_size
	output fifo_word_t   rd_data,
	output fifo_count_t  rd_size      // Committed words ready to read
);

	// Buffer sized from the shared depth
	packet_fifo #(
		.DEPTH (`FIFO_DEPTH)
	) i_fifo (
		.wr_clk   (wr_clk),
		.wr_reset (wr_reset),
		.wr_req   (wr_req),
		.wr_size  (wr_size),
		.rd_clk   (rd_clk),
		.rd_reset (rd_reset),
		.rd_req   (rd_req),
		.rd_data  (rd_data),
		.rd_size  (rd_size)
	);

endmodule

// ==== tests/packet_fifo_vectors.svh ====
`ifndef PACKET_FIFO_VECTORS_SVH
`define PACKET_FIFO_VECTORS_SVH

// How a step ends its packet
localparam logic FINISH_COMMIT   = 1'b0;
localparam logic FINISH_ROLLBACK = 1'b1;

// What the reader frees once the packet is finished
localparam logic [1:0] POP_NONE   = 2'd0;
localparam logic [1:0] POP_SINGLE = 2'd1;
localparam logic [1:0] POP_PACKET = 2'd2;

typedef struct packed {
	logic [4:0] len;          // Words pushed, 0 to 16
	logic       finish;       // Commit or rollback
	logic [1:0] pop;          // Pop kind after the push
	logic [4:0] exp_rd_size;  // rd_size once everything settles
} step_t;

string step_names[$];
step_t steps[$];

task automatic add_step(input string name, input int len, input logic finish,
		input logic [1:0] pop, input int exp_rd_size);
	step_t s;
	s.len         = len[4:0];
	s.finish      = finish;
	s.pop         = pop;
	s.exp_rd_size = exp_rd_size[4:0];
	step_names.push_back(name);
	steps.push_back(s);
endtask

// Columns: name, length, finish, pop kind, expected rd_size after settling
task automatic load_steps();
	add_step("first_commit",  5,  FINISH_COMMIT,   POP_NONE,   5);
	add_step("rollback",      3,  FINISH_ROLLBACK, POP_NONE,   5);
	add_step("after_rollback", 4, FINISH_COMMIT,   POP_NONE,   9);   // Overwrites dropped words
	add_step("pop_single",    0,  FINISH_COMMIT,   POP_SINGLE, 8);
	add_step("pop_packet",    0,  FINISH_COMMIT,   POP_PACKET, 4);   // Rest of the first packet
	add_step("pop_packet_2",  0,  FINISH_COMMIT,   POP_PACKET, 0);
	add_step("empty_pop",     0,  FINISH_COMMIT,   POP_SINGLE, 0);   // Must be ignored
	add_step("fill_a",        7,  FINISH_COMMIT,   POP_NONE,   7);
	add_step("fill_b",        9,  FINISH_COMMIT,   POP_NONE,   16);  // Full, wr_size 0
	add_step("drain_a",       0,  FINISH_COMMIT,   POP_PACKET, 9);
	add_step("wrap_push",     5,  FINISH_COMMIT,   POP_NONE,   14);  // Pointers wrap here
	add_step("wrap_single",   0,  FINISH_COMMIT,   POP_SINGLE, 13);
	add_step("wrap_rollback", 2,  FINISH_ROLLBACK, POP_PACKET, 5);
	add_step("drain_all",     0,  FINISH_COMMIT,   POP_PACKET, 0);
	add_step("refill",        16, FINISH_COMMIT,   POP_NONE,   16);
	add_step("final_drain",   0,  FINISH_COMMIT,   POP_PACKET, 0);
endtask

`endif

// ==== tests/packet_fifo_tb.sv ====
`timescale 1ns/1ps
`include "fifo_defs.svh"

module packet_fifo_tb
	import fifo_pkg::*;
;

	`include "packet_fifo_vectors.svh"

	localparam int DEPTH          = `FIFO_DEPTH;
	localparam int WAIT_LIMIT     = 40;     // Cycles per settle wait
	localparam int TIMEOUT_CYCLES = 4000;   // 16 steps of at most ~210 rd_clk cycles plus margin

	logic         wr_clk;
	logic         rd_clk;
	logic         wr_reset;
	logic         rd_reset;
	fifo_wr_req_t wr_req;
	fifo_rd_req_t rd_req;
	fifo_word_t   rd_data;
	fifo_count_t  rd_size;
	fifo_count_t  wr_size;

	fifo_word_t model_words[$];   // Committed words with the oldest first
	int         packet_lens[$];   // Words left in each committed packet
	int         errors      = 0;
	int         cycle_count = 0;

	packet_fifo_top i_dut (
		.wr_clk   (wr_clk),
		.wr_reset (wr_reset),
		.wr_req   (wr_req),
		.wr_size  (wr_size),
		.rd_clk   (rd_clk),
		.rd_reset (rd_reset),
		.rd_req   (rd_req),
		.rd_data  (rd_data),
		.rd_size  (rd_size)
	);

	//////////////////////////////////////////////////
	// Clocks and run limit

	initial begin
		rd_clk = 1'b0;
		forever #20 rd_clk = ~rd_clk;   // 40 ns
	end

	initial begin
		wr_clk = 1'b0;
		forever #14 wr_clk = ~wr_clk;   // 28 ns and unrelated to rd_clk
	end

	always @(posedge rd_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Run stopped after %0d rd_clk cycles without finishing", cycle_count);
			$display("Some tests failed");
			$fatal(1);
		end
	end

	//////////////////////////////////////////////////
	// Checks and waits

	task automatic check_count(input string name, input string what, input int exp,
			input int act);
		assert (act == exp) else begin
			errors++;
			$display("[FAIL] %s %s: expected %0d, actual %0d", name, what, exp, act);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	// Poll until the synced count catches up with the model
	task automatic wait_rd_size(input string name, input int exp);
		int n;
		n = 0;
		@(negedge rd_clk);
		while (int'(rd_size) != exp && n < WAIT_LIMIT) begin
			@(negedge rd_clk);
			n++;
		end
		if (int'(rd_size) != exp) begin
			$display("Step %s: rd_size never reached %0d within %0d cycles", name, exp, n);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic wait_wr_size(input string name, input int exp);
		int n;
		n = 0;
		@(negedge wr_clk);
		while (int'(wr_size) != exp && n < WAIT_LIMIT) begin
			@(negedge wr_clk);
			n++;
		end
		if (int'(wr_size) != exp) begin
			$display("Step %s: wr_size never reached %0d within %0d cycles", name, exp, n);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	//////////////////////////////////////////////////
	// Producer and consumer actions

	task automatic push_packet(input int len, input logic finish);
		fifo_word_t pending[$];   // Pushed but not yet committed
		fifo_word_t word;
		int         k;
		for (k = 0; k < len; k++) begin
			@(negedge wr_clk);
			word        = $urandom;
			wr_req.en   = 1'b1;
			wr_req.data = word;
			pending.push_back(word);
		end
		@(negedge wr_clk);
		wr_req.en       = 1'b0;
		wr_req.commit   = (finish == FINISH_COMMIT);
		wr_req.rollback = (finish == FINISH_ROLLBACK);
		@(negedge wr_clk);
		wr_req.commit   = 1'b0;
		wr_req.rollback = 1'b0;
		if (finish == FINISH_COMMIT && len > 0) begin
			for (k = 0; k < len; k++)
				model_words.push_back(pending[k]);
			packet_lens.push_back(len);
		end
	endtask

	task automatic pop_words(input logic [1:0] kind);
		int n;
		if (kind == POP_NONE)
			return;
		@(negedge rd_clk);
		if (kind == POP_SINGLE) begin
			rd_req.pop_single = 1'b1;
			if (model_words.size() > 0) begin   // Empty pop frees nothing
				void'(model_words.pop_front());
				packet_lens[0] = packet_lens[0] - 1;
				if (packet_lens[0] == 0)
					void'(packet_lens.pop_front());
			end
		end else begin
			n                  = packet_lens.pop_front();
			rd_req.pop_packet  = 1'b1;
			rd_req.packet_size = fifo_count_t'(n);
			repeat (n) void'(model_words.pop_front());
		end
		@(negedge rd_clk);
		rd_req.pop_single = 1'b0;
		rd_req.pop_packet = 1'b0;
	endtask

	// One read at a time through the RAM and output registers
	task automatic read_all(input string name);
		int k;
		for (k = 0; k < model_words.size(); k++) begin
			@(negedge rd_clk);
			rd_req.en     = 1'b1;
			rd_req.offset = fifo_addr_t'(k);
			@(negedge rd_clk);
			rd_req.en = 1'b0;
			@(negedge rd_clk);
			assert (rd_data == model_words[k]) else begin
				errors++;
				$display("[FAIL] %s offset %0d: expected %h, actual %h",
					name, k, model_words[k], rd_data);
				$display("Some tests failed");
				$fatal(1);
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		int i;
		wr_req   = '0;
		rd_req   = '0;
		wr_reset = 1'b1;
		rd_reset = 1'b1;
		void'($urandom(32'hfec4_6b4f));
		load_steps();

		repeat (8) @(negedge rd_clk);
		rd_reset = 1'b0;
		@(negedge wr_clk);
		wr_reset = 1'b0;

		@(negedge rd_clk);
		check_count("reset", "rd_size", 0, rd_size);
		check_count("reset", "wr_size", DEPTH, wr_size);

		for (i = 0; i < steps.size(); i++) begin
			push_packet(steps[i].len, steps[i].finish);
			wait_wr_size(step_names[i], DEPTH - model_words.size());
			wait_rd_size(step_names[i], model_words.size());
			pop_words(steps[i].pop);
			wait_wr_size(step_names[i], DEPTH - model_words.size());
			// Free space once settled is whatever the table leaves unread
			check_count(step_names[i], "wr_size", DEPTH - int'(steps[i].exp_rd_size), wr_size);
			wait_rd_size(step_names[i], model_words.size());
			check_count(step_names[i], "rd_size", steps[i].exp_rd_size, rd_size);
			read_all(step_names[i]);
		end

		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+logic
+incdir+tests
logic/fifo_pkg.sv
logic/dual_clock_ram.sv
logic/handshake_sync.sv
logic/packet_fifo.sv
logic/packet_fifo_top.sv
tests/packet_fifo_tb.sv
